// File: common/cpu_bus_if.sv
`timescale 1ns/1ps

// one register access from the decoder to a slave block
interface cpu_bus_if;

	logic                            cs;    // slave selected, held until ack
	logic                            wr;
	logic [mpu_pkg::BUS_ADR_W-1:0]   adr;   // word offset inside the block
	logic [mpu_pkg::DATA_W-1:0]      wdat;
	logic [mpu_pkg::DATA_W-1:0]      rdat;
	logic                            ack;   // second cycle of cs

	modport master (
		output cs,
		output wr,
		output adr,
		output wdat,
		input  rdat,
		input  ack
	);

	modport slave (
		input  cs,
		input  wr,
		input  adr,
		input  wdat,
		output rdat,
		output ack
	);

endinterface

// File: common/mpu_pkg.sv
package mpu_pkg;

	// ========================================================================
	// bus widths
	// ========================================================================
	localparam int ADR_W     = 32;           // cpu and memory byte address
	localparam int DATA_W    = 32;
	localparam int SEL_W     = 2;            // byte lane strobes
	localparam int BUS_ADR_W = 9;            // register word offset on cpu_bus_if

	// ========================================================================
	// address map
	// ========================================================================
	localparam int          IO_TAG_W    = 12;            // top bits that tag the i/o region
	localparam logic [11:0] IO_BASE     = 12'hFFD;       // 0xFFDx_xxxx never reaches memory
	localparam logic [31:0] PIC_BASE    = 32'hFFD0_0F00;
	localparam logic [31:0] MMU_BASE    = 32'hFFD0_4000;
	localparam int          BLK_SEL_BIT = 14;            // 0 selects pic, 1 selects mmu
	localparam int          BLK_OFS_W   = 16;            // byte offset width inside a block

	// pic register word offsets
	localparam logic [BUS_ADR_W-1:0] PIC_STATUS   = 9'd0;  // pending and enabled, ro
	localparam logic [BUS_ADR_W-1:0] PIC_ENABLE   = 9'd1;
	localparam logic [BUS_ADR_W-1:0] PIC_EDGE     = 9'd2;  // 1 edge, 0 level
	localparam logic [BUS_ADR_W-1:0] PIC_ACK      = 9'd3;  // write source number
	localparam logic [BUS_ADR_W-1:0] PIC_BASE_REG = 9'd4;  // cause base

	// mmu register word offsets, map entries sit at 0..63
	localparam logic [BUS_ADR_W-1:0] MMU_CTRL = 9'h100;    // bit 0 enables paging

	// ========================================================================
	// interrupt controller
	// ========================================================================
	localparam int NUM_SRC  = 32;
	localparam int SRC_W    = 5;
	localparam int TICK_SRC = 3;             // built-in periodic tick
	localparam int BASE_W   = 4;
	localparam int CAUSE_W  = 9;             // base over source number

	// ========================================================================
	// page map
	// ========================================================================
	localparam int PAGE_OFS_W  = 14;         // 16 KB pages
	localparam int MAP_IDX_W   = 6;
	localparam int MAP_ENTRIES = 64;
	localparam int PPN_W       = 18;
	localparam int PAGED_LIMIT = 20;         // bits from here up must be zero to translate

endpackage

// File: hw/bus_responder.sv
`timescale 1ns/1ps

module bus_responder (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       vpa_i,
	input  logic                       vda_i,
	input  logic                       wr_i,
	input  logic [mpu_pkg::ADR_W-1:0]  adr_i,
	input  logic [mpu_pkg::DATA_W-1:0] dat_i,
	input  logic [mpu_pkg::DATA_W-1:0] mem_dat_i,
	input  logic                       mem_rdy_i,
	cpu_bus_if.master                  pic_bus,
	cpu_bus_if.master                  mmu_bus,
	output logic [mpu_pkg::DATA_W-1:0] dat_o,
	output logic                       rdy_o
);

	logic                          cyc;
	logic                          is_io;
	logic                          mmu_blk;    // block select bit inside i/o
	logic [mpu_pkg::BLK_OFS_W-1:0] pic_ofs;    // byte offset from block base
	logic [mpu_pkg::BLK_OFS_W-1:0] mmu_ofs;

	assign cyc     = vpa_i | vda_i;
	assign is_io   = adr_i[mpu_pkg::ADR_W-1 -: mpu_pkg::IO_TAG_W] == mpu_pkg::IO_BASE;
	assign mmu_blk = adr_i[mpu_pkg::BLK_SEL_BIT];
	assign pic_ofs = adr_i[mpu_pkg::BLK_OFS_W-1:0] - mpu_pkg::PIC_BASE[mpu_pkg::BLK_OFS_W-1:0];
	assign mmu_ofs = adr_i[mpu_pkg::BLK_OFS_W-1:0] - mpu_pkg::MMU_BASE[mpu_pkg::BLK_OFS_W-1:0];

	// ========================================================================
	// slave selects, held as long as the core holds the request
	// ========================================================================
	assign pic_bus.cs   = cyc & is_io & ~mmu_blk;
	assign pic_bus.wr   = wr_i;
	assign pic_bus.adr  = pic_ofs[mpu_pkg::BUS_ADR_W+1:2];   // bytes to words
	assign pic_bus.wdat = dat_i;

	assign mmu_bus.cs   = cyc & is_io & mmu_blk;
	assign mmu_bus.wr   = wr_i;
	assign mmu_bus.adr  = mmu_ofs[mpu_pkg::BUS_ADR_W+1:2];
	assign mmu_bus.wdat = dat_i;

	// ========================================================================
	// read data and ready back to the core
	// ========================================================================
	always_comb begin
		if (!is_io)
			dat_o = mem_dat_i;
		else if (mmu_blk)
			dat_o = mmu_bus.rdat;
		else
			dat_o = pic_bus.rdat;
	end

	// memory stalls pass straight through, register slaves give one wait state
	assign rdy_o = is_io ? (pic_bus.ack | mmu_bus.ack) : mem_rdy_i;

	// register ready never comes in the first cycle of an i/o request
	a_io_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(cyc && is_io && rdy_o) |-> $past(cyc && is_io));

endmodule

// File: hw/mpu_top.sv
`timescale 1ns/1ps

module mpu_top #(
	parameter int CLK_FREQ = 50000000,
	parameter int TICK_HZ  = 30
) (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	// cpu side
	input  logic                        vpa_i,
	input  logic                        vda_i,
	input  logic                        wr_i,
	input  logic [mpu_pkg::SEL_W-1:0]   sel_i,
	input  logic [mpu_pkg::ADR_W-1:0]   adr_i,
	input  logic [mpu_pkg::DATA_W-1:0]  dat_i,
	output logic [mpu_pkg::DATA_W-1:0]  dat_o,
	output logic                        rdy_o,
	// memory side
	output logic                        vpa_o,
	output logic                        vda_o,
	output logic                        wr_o,
	output logic [mpu_pkg::SEL_W-1:0]   sel_o,
	output logic [mpu_pkg::ADR_W-1:0]   adr_o,
	output logic [mpu_pkg::DATA_W-1:0]  dat_o_mem,
	input  logic [mpu_pkg::DATA_W-1:0]  mem_dat_i,
	input  logic                        mem_rdy_i,
	// interrupts
	input  logic [mpu_pkg::NUM_SRC-1:0] irq_src_i,
	output logic                        irq_o,
	output logic [mpu_pkg::CAUSE_W-1:0] cause_o
);

	logic                        tick;
	logic [mpu_pkg::NUM_SRC-1:0] irq_lvl;
	logic [mpu_pkg::NUM_SRC-1:0] irq_rise;

	cpu_bus_if pic_bus ();
	cpu_bus_if mmu_bus ();

	assign dat_o_mem = dat_i;            // write data goes out as is

	tick_gen #(.CLK_FREQ(CLK_FREQ), .TICK_HZ(TICK_HZ)) u_tick (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .tick_o(tick)
	);

	irq_capture u_cap (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .irq_src_i(irq_src_i),
		.lvl_o(irq_lvl), .rise_o(irq_rise)
	);

	pic_ctrl u_pic (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .lvl_i(irq_lvl), .rise_i(irq_rise),
		.tick_i(tick), .bus(pic_bus), .irq_o(irq_o), .cause_o(cause_o)
	);

	page_mapper u_mmu (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .vpa_i(vpa_i), .vda_i(vda_i), .wr_i(wr_i),
		.sel_i(sel_i), .vadr_i(adr_i), .bus(mmu_bus), .vpa_o(vpa_o), .vda_o(vda_o),
		.wr_o(wr_o), .sel_o(sel_o), .padr_o(adr_o)
	);

	bus_responder u_resp (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .vpa_i(vpa_i), .vda_i(vda_i), .wr_i(wr_i),
		.adr_i(adr_i), .dat_i(dat_i), .mem_dat_i(mem_dat_i), .mem_rdy_i(mem_rdy_i),
		.pic_bus(pic_bus), .mmu_bus(mmu_bus), .dat_o(dat_o), .rdy_o(rdy_o)
	);

endmodule

// File: hw/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
	parameter int CLK_FREQ = 50000000,
	parameter int TICK_HZ  = 30
) (
	input  logic clk_i,
	input  logic rst_n_i,
	output logic tick_o
);

	localparam int DIV   = CLK_FREQ / TICK_HZ;              // clocks per tick
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DIV - 1);

	logic [CNT_W-1:0] cnt_q;

	// down-counter, zero reloads so one period is DIV clocks
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			cnt_q  <= '0;
			tick_o <= 1'b0;
		end else begin
			if (cnt_q == '0)
				cnt_q <= RELOAD;
			else
				cnt_q <= cnt_q - 1'b1;
			tick_o <= (cnt_q == CNT_W'(1));    // pulse lines up with count hitting zero
		end
	end

	// single-cycle pulse, pic latches it as an edge
	a_tick_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		tick_o |=> !tick_o);

endmodule

// File: mmu/page_mapper.sv
`timescale 1ns/1ps

module page_mapper (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  logic                      vpa_i,
	input  logic                      vda_i,
	input  logic                      wr_i,
	input  logic [mpu_pkg::SEL_W-1:0] sel_i,
	input  logic [mpu_pkg::ADR_W-1:0] vadr_i,
	cpu_bus_if.slave                  bus,
	output logic                      vpa_o,
	output logic                      vda_o,
	output logic                      wr_o,
	output logic [mpu_pkg::SEL_W-1:0] sel_o,
	output logic [mpu_pkg::ADR_W-1:0] padr_o
);

	logic [mpu_pkg::PPN_W-1:0]     map_q [mpu_pkg::MAP_ENTRIES];
	logic [mpu_pkg::MAP_IDX_W-1:0] idx;
	logic                          paging_q;
	logic                          ack_q;
	logic                          wr_en;
	logic                          map_hit;    // register offset falls on a map entry
	logic                          is_io;
	logic                          in_paged;

	// ========================================================================
	// translation
	// ========================================================================
	assign is_io    = vadr_i[mpu_pkg::ADR_W-1 -: mpu_pkg::IO_TAG_W] == mpu_pkg::IO_BASE;
	assign in_paged = paging_q && (vadr_i[mpu_pkg::ADR_W-1:mpu_pkg::PAGED_LIMIT] == '0);
	assign idx      = vadr_i[mpu_pkg::PAGE_OFS_W +: mpu_pkg::MAP_IDX_W];

	// mapped page over the untouched page offset
	assign padr_o = in_paged ? {map_q[idx], vadr_i[mpu_pkg::PAGE_OFS_W-1:0]} : vadr_i;
	assign vpa_o  = vpa_i & ~is_io;          // i/o is served on chip
	assign vda_o  = vda_i & ~is_io;
	assign wr_o   = wr_i;
	assign sel_o  = sel_i;

	// ========================================================================
	// register port
	// ========================================================================
	assign map_hit = bus.adr[mpu_pkg::BUS_ADR_W-1:mpu_pkg::MAP_IDX_W] == '0;
	assign bus.ack = ack_q & bus.cs;
	assign wr_en   = bus.ack & bus.wr;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_q    <= 1'b0;
			paging_q <= 1'b0;                 // come up unmapped
		end else begin
			ack_q <= bus.cs & ~ack_q;
			if (wr_en && bus.adr == mpu_pkg::MMU_CTRL)
				paging_q <= bus.wdat[0];
		end
	end

	// map table, contents undefined until software fills it
	always_ff @(posedge clk_i) begin
		if (wr_en && map_hit)
			map_q[bus.adr[mpu_pkg::MAP_IDX_W-1:0]] <= bus.wdat[mpu_pkg::PPN_W-1:0];
	end

	always_comb begin
		if (map_hit)
			bus.rdat = {{(mpu_pkg::DATA_W-mpu_pkg::PPN_W){1'b0}},
				map_q[bus.adr[mpu_pkg::MAP_IDX_W-1:0]]};
		else if (bus.adr == mpu_pkg::MMU_CTRL)
			bus.rdat = {{(mpu_pkg::DATA_W-1){1'b0}}, paging_q};
		else
			bus.rdat = '0;
	end

	// memory strobes and a register access never overlap
	a_no_io_mem: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(vda_o || vpa_o) |-> !bus.cs);

endmodule

// File: pic/irq_capture.sv
`timescale 1ns/1ps

module irq_capture (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic [mpu_pkg::NUM_SRC-1:0] irq_src_i,  // async level lines
	output logic [mpu_pkg::NUM_SRC-1:0] lvl_o,
	output logic [mpu_pkg::NUM_SRC-1:0] rise_o
);

	logic [mpu_pkg::NUM_SRC-1:0] sync1_q;
	logic [mpu_pkg::NUM_SRC-1:0] sync2_q;
	logic [mpu_pkg::NUM_SRC-1:0] dly_q;
	logic [mpu_pkg::NUM_SRC-1:0] rise_q;

	// ========================================================================
	// two-flop synchronizer, then edge detect
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			sync1_q <= '0;
			sync2_q <= '0;
			dly_q   <= '0;
			rise_q  <= '0;
		end else begin
			sync1_q <= irq_src_i;                  // may go metastable
			sync2_q <= sync1_q;                    // settled copy
			dly_q   <= sync2_q;                    // previous settled value
			rise_q  <= sync2_q & ~dly_q;           // low to high seen this cycle
		end
	end

	// level straight from the synchronizer, edge pulse one stage later
	assign lvl_o  = sync2_q;
	assign rise_o = rise_q;

endmodule

// File: pic/pic_ctrl.sv
`timescale 1ns/1ps

module pic_ctrl (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic [mpu_pkg::NUM_SRC-1:0] lvl_i,    // synchronized levels
	input  logic [mpu_pkg::NUM_SRC-1:0] rise_i,   // one-cycle edge pulses
	input  logic                        tick_i,
	cpu_bus_if.slave                    bus,
	output logic                        irq_o,
	output logic [mpu_pkg::CAUSE_W-1:0] cause_o
);

	logic [mpu_pkg::NUM_SRC-1:0] enable_q;
	logic [mpu_pkg::NUM_SRC-1:0] edge_sel_q;     // 1 edge mode, 0 level mode
	logic [mpu_pkg::NUM_SRC-1:0] lvl_q;
	logic [mpu_pkg::NUM_SRC-1:0] edge_q;         // edge pending latch
	logic [mpu_pkg::NUM_SRC-1:0] edge_in;
	logic [mpu_pkg::NUM_SRC-1:0] ack_clr;
	logic [mpu_pkg::NUM_SRC-1:0] req;
	logic [mpu_pkg::BASE_W-1:0]  base_q;
	logic [mpu_pkg::SRC_W-1:0]   top_src;
	logic                        ack_q;
	logic                        wr_en;

	// ========================================================================
	// register port, one wait state
	// ========================================================================
	always_ff @(posedge clk_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= bus.cs & ~ack_q;          // drops after the ack cycle
	end

	assign bus.ack = ack_q & bus.cs;
	assign wr_en   = bus.ack & bus.wr;       // writes land on the ack edge

	// tick joins the edge path of its source
	assign edge_in = rise_i | (mpu_pkg::NUM_SRC'(tick_i) << mpu_pkg::TICK_SRC);
	assign ack_clr = (wr_en && bus.adr == mpu_pkg::PIC_ACK) ?
		(mpu_pkg::NUM_SRC'(1) << bus.wdat[mpu_pkg::SRC_W-1:0]) : '0;

	// source 0 is never a request
	assign req = enable_q & ((edge_sel_q & edge_q) | (~edge_sel_q & lvl_q))
		& ~mpu_pkg::NUM_SRC'(1);

	// highest numbered request wins
	always_comb begin
		top_src = '0;
		for (int i = 0; i < mpu_pkg::NUM_SRC; i++) begin
			if (req[i])
				top_src = mpu_pkg::SRC_W'(i);
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			enable_q   <= '0;
			edge_sel_q <= '0;
			base_q     <= '0;
			lvl_q      <= '0;
			edge_q     <= '0;
			irq_o      <= 1'b0;
			cause_o    <= '0;
		end else begin
			lvl_q  <= lvl_i;
			edge_q <= (edge_q & ~ack_clr) | edge_in;   // a fresh edge beats the ack
			if (wr_en) begin
				case (bus.adr)
					mpu_pkg::PIC_ENABLE:   enable_q   <= bus.wdat;
					mpu_pkg::PIC_EDGE:     edge_sel_q <= bus.wdat;
					mpu_pkg::PIC_BASE_REG: base_q     <= bus.wdat[mpu_pkg::BASE_W-1:0];
					default: ;                           // status ro, ack handled above
				endcase
			end
			irq_o   <= |req;
			cause_o <= (|req) ? {base_q, top_src} : '0;
		end
	end

	always_comb begin
		case (bus.adr)
			mpu_pkg::PIC_STATUS:   bus.rdat = req;
			mpu_pkg::PIC_ENABLE:   bus.rdat = enable_q;
			mpu_pkg::PIC_EDGE:     bus.rdat = edge_sel_q;
			mpu_pkg::PIC_BASE_REG: bus.rdat = {{(mpu_pkg::DATA_W-mpu_pkg::BASE_W){1'b0}}, base_q};
			default:               bus.rdat = '0;    // ack and holes read zero
		endcase
	end

	// a raised irq never names source 0
	a_cause_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		irq_o |-> (cause_o[mpu_pkg::SRC_W-1:0] != '0));

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the mpu testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_mpu \
	-o sim_mpu > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_mpu > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || { echo "no result line in sim.log"; exit 1; }
exit 0

// File: test/tb_model.svh
// ==========================================================================
// reference model state, random source and compare
// ==========================================================================
int          err_cnt = 0;
int          chk_cnt = 0;
logic [31:0] seed = 32'hc714_cce3;
logic [31:0] mem_seed = 32'hc714_cce3 ^ 32'h0000_ffff;   // own stream for the memory

logic [17:0] map_m [64];       // page map contents as written
logic [63:0] map_valid_m;      // entries written so far
logic        paging_m;
logic [31:0] enable_m;
logic [31:0] edge_m;
logic [3:0]  base_m;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// upper half moved down, low lcg bits are weak
function automatic logic [31:0] next_rand();
	seed = lcg_next(seed);
	return {seed[15:0], seed[31:16]};
endfunction

// memory contents depend on every address bit
function automatic logic [31:0] mem_word(input logic [31:0] a);
	return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9) ^ 32'ha5c3_0f69;
endfunction

// 16 KB page, mapped page on top of the offset
function automatic logic [31:0] model_xlate(input logic [31:0] a);
	if (paging_m && a[31:20] == 12'h000)
		return {map_m[a[19:14]], a[13:0]};
	return a;
endfunction

function automatic logic [4:0] highest_src(input logic [31:0] act);
	logic [4:0] top;
	top = '0;
	for (int i = 1; i < 32; i++)
		if (act[i])
			top = 5'(i);
	return top;
endfunction

function automatic logic [8:0] model_cause(input logic [31:0] act);
	if (act == '0)
		return '0;
	return {base_m, highest_src(act)};
endfunction

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
	chk_cnt++;
	if (exp !== act) begin
		err_cnt++;
		$display("** Error %s: expected %h, actual %h", name, exp, act);
	end
endtask

// File: test/tb_mpu.sv
`timescale 1ns/1ps

module tb_mpu;

	logic        clk_i = 1'b0;
	logic        rst_n_i;
	logic        vpa_i, vda_i, wr_i;
	logic [1:0]  sel_i;
	logic [31:0] adr_i, dat_i, dat_o, mem_dat_i;
	logic        rdy_o, vpa_o, vda_o, wr_o, mem_rdy_i, irq_o;
	logic [1:0]  sel_o;
	logic [31:0] adr_o, dat_o_mem, irq_src_i;
	logic [8:0]  cause_o;
	int          mem_wait;       // stall cycles left for the current memory access
	int          test_cnt = 0;

	`include "tb_model.svh"

	mpu_top #(.CLK_FREQ(3000), .TICK_HZ(30)) mpu_i (.*);

	always #20 clk_i = ~clk_i;    // 40 ns

	// memory responder, random 0..3 cycle stall per access
	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			mem_rdy_i <= 1'b0;
			mem_wait  <= 0;
		end else if ((vda_o || vpa_o) && !mem_rdy_i) begin
			if (mem_wait == 0) begin
				mem_rdy_i <= 1'b1;
				mem_dat_i <= mem_word(adr_o);
			end else
				mem_wait <= mem_wait - 1;
		end else begin
			mem_rdy_i <= 1'b0;
			mem_seed   = lcg_next(mem_seed);
			mem_wait  <= int'(mem_seed[25:24]);
		end
	end

	// one cpu access, held until rdy_o
	task automatic cpu_access(input logic wr, input logic [31:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat, output logic [31:0] padr, output logic mem_seen);
		logic        done;
		logic        prog;
		logic [1:0]  sel;
		logic [31:0] r;
		done     = 1'b0;
		mem_seen = 1'b0;
		rdat     = '0;
		padr     = '0;
		r        = next_rand();
		prog     = !wr && r[0];           // some reads go out as program fetches
		sel      = r[2:1];
		@(posedge clk_i);
		vpa_i <= prog;
		vda_i <= !prog;
		wr_i  <= wr;
		adr_i <= adr;
		dat_i <= wdat;
		sel_i <= sel;
		for (int n = 0; n < 40 && !done; n++) begin
			@(negedge clk_i);             // outputs settled here
			if (vda_o || vpa_o)
				mem_seen = 1'b1;
			padr = adr_o;
			if (rdy_o) begin
				rdat = dat_o;
				done = 1'b1;
				if (vda_o || vpa_o) begin
					check_val("mem vpa", 32'(prog), 32'(vpa_o));
					check_val("mem vda", 32'(!prog), 32'(vda_o));
					check_val("mem wr", 32'(wr), 32'(wr_o));
					check_val("mem sel", 32'(sel), 32'(sel_o));
					check_val("mem wdat", wdat, dat_o_mem);
				end
			end
		end
		@(posedge clk_i);                 // completing edge
		vpa_i <= 1'b0;
		vda_i <= 1'b0;
		wr_i  <= 1'b0;
		if (!done) begin
			err_cnt++;
			$display("access to %h never got a ready", adr);
		end
	endtask

	task automatic io_write(input logic [31:0] adr, input logic [31:0] wdat);
		logic [31:0] rd, pa;
		logic        seen;
		cpu_access(1'b1, adr, wdat, rd, pa, seen);
		check_val("io write strobe", 32'd0, 32'(seen));
	endtask

	task automatic io_read(input string name, input logic [31:0] adr, input logic [31:0] exp);
		logic [31:0] rd, pa;
		logic        seen;
		cpu_access(1'b0, adr, 32'd0, rd, pa, seen);
		check_val({name, " strobe"}, 32'd0, 32'(seen));
		check_val(name, exp, rd);
	endtask

	task automatic mem_read(input string name, input logic [31:0] adr);
		logic [31:0] rd, pa;
		logic        seen;
		cpu_access(1'b0, adr, 32'd0, rd, pa, seen);
		check_val({name, " strobe"}, 32'd1, 32'(seen));
		check_val({name, " adr"}, model_xlate(adr), pa);
		check_val({name, " data"}, mem_word(model_xlate(adr)), rd);
	endtask

	// bounded wait for irq_o to reach a level
	task automatic wait_irq(input logic lvl, input int limit);
		int n;
		n = 0;
		while (irq_o !== lvl && n < limit) begin
			@(negedge clk_i);
			n++;
		end
		if (irq_o !== lvl) begin
			err_cnt++;
			$display("irq_o did not go to %0d within %0d cycles", lvl, limit);
		end
	endtask

	task automatic test_done(input string name, input int errs_before);
		test_cnt++;
		$display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
	endtask

	function automatic logic [31:0] pic_adr(input int reg_no);
		return mpu_pkg::PIC_BASE + 32'(reg_no * 4);
	endfunction

	initial begin
		int          e;
		int          k;
		int          idx;
		int          wlist [$];
		logic [31:0] a, v, src, act;
		logic [31:0] pa;
		logic        seen;
		rst_n_i   = 1'b0;
		vpa_i     = 1'b0;
		vda_i     = 1'b0;
		wr_i      = 1'b0;
		sel_i     = '0;
		adr_i     = '0;
		dat_i     = '0;
		mem_dat_i = '0;
		mem_rdy_i = 1'b0;
		irq_src_i = '0;
		paging_m    = 1'b0;
		enable_m    = '0;
		edge_m      = '0;
		base_m      = '0;
		map_valid_m = '0;
		repeat (3) @(posedge clk_i);
		rst_n_i <= 1'b1;

		// ==================================================================
		// 1 reset state and pass-through
		// ==================================================================
		e = err_cnt;
		@(negedge clk_i);
		check_val("reset irq", 32'd0, 32'(irq_o));
		check_val("reset cause", 32'd0, 32'(cause_o));
		for (int i = 0; i < 10; i++)
			mem_read("flat read", next_rand() & 32'h7fff_fffc);
		for (int i = 0; i < 5; i++) begin
			a = next_rand() & 32'h7fff_fffc;
			cpu_access(1'b1, a, next_rand(), v, pa, seen);
			check_val("flat write strobe", 32'd1, 32'(seen));
			check_val("flat write adr", a, pa);
		end
		test_done("reset and pass-through", e);

		// ==================================================================
		// 2 page map
		// ==================================================================
		e = err_cnt;
		for (int i = 0; i < 10; i++) begin
			idx = int'(next_rand() % 64);
			v   = next_rand() & 32'h0003_ffff;
			io_write(mpu_pkg::MMU_BASE + 32'(idx * 4), v);
			map_m[idx] = v[17:0];
			if (!map_valid_m[idx])
				wlist.push_back(idx);
			map_valid_m[idx] = 1'b1;
		end
		foreach (wlist[i])
			io_read("map readback", mpu_pkg::MMU_BASE + 32'(wlist[i] * 4), 32'(map_m[wlist[i]]));
		io_write(mpu_pkg::MMU_BASE + 32'h400, 32'd1);
		paging_m = 1'b1;
		io_read("paging ctrl", mpu_pkg::MMU_BASE + 32'h400, 32'd1);
		for (int i = 0; i < 10; i++) begin
			idx = wlist[next_rand() % wlist.size()];    // only entries with known contents
			a   = {12'h000, 6'(idx), 14'(next_rand() & 32'h3ffc)};
			mem_read("paged read", a);
		end
		for (int i = 0; i < 5; i++)
			mem_read("above limit", (next_rand() & 32'h7fff_fffc) | 32'h0010_0000);
		test_done("page map", e);

		// ==================================================================
		// 3 i/o registers
		// ==================================================================
		e = err_cnt;
		base_m   = 4'(next_rand());
		enable_m = next_rand();
		edge_m   = next_rand();
		io_write(pic_adr(4), 32'(base_m));
		io_write(pic_adr(1), enable_m);
		io_write(pic_adr(2), edge_m);
		for (int i = 0; i < 12; i++) begin
			case (next_rand() % 5)
				0: io_read("pic enable", pic_adr(1), enable_m);
				1: io_read("pic edge", pic_adr(2), edge_m);
				2: io_read("pic base", pic_adr(4), 32'(base_m));
				3: io_read("mmu ctrl", mpu_pkg::MMU_BASE + 32'h400, 32'(paging_m));
				default: begin
					idx = wlist[next_rand() % wlist.size()];
					io_read("map entry", mpu_pkg::MMU_BASE + 32'(idx * 4), 32'(map_m[idx]));
				end
			endcase
		end
		test_done("i/o registers", e);

		// ==================================================================
		// 4 external sources
		// ==================================================================
		e = err_cnt;
		k        = 4 + int'(next_rand() % 28);
		enable_m = (next_rand() | (32'd1 << k)) & ~32'h0000_0008;   // tick kept out
		edge_m   = next_rand();
		base_m   = 4'(next_rand());
		io_write(pic_adr(1), enable_m);
		io_write(pic_adr(2), edge_m);
		io_write(pic_adr(4), 32'(base_m));
		src = next_rand() | (32'd1 << k);
		@(posedge clk_i);
		irq_src_i <= src;
		act = src & enable_m & ~32'h0000_0009;    // sources held, edge and level alike
		wait_irq(1'b1, 20);
		@(negedge clk_i);
		check_val("cause", 32'(model_cause(act)), 32'(cause_o));
		io_read("status", pic_adr(0), act);
		if ((act & edge_m) != '0) begin
			idx = int'(highest_src(act & edge_m));
			io_write(pic_adr(3), 32'(idx));
			act = act & ~(32'd1 << idx);
			io_read("status after ack", pic_adr(0), act);
		end
		@(posedge clk_i);
		irq_src_i <= '0;
		enable_m = '0;
		io_write(pic_adr(1), enable_m);
		test_done("external sources", e);

		// ==================================================================
		// 5 tick
		// ==================================================================
		e = err_cnt;
		edge_m   = 32'h0000_0008;
		enable_m = 32'h0000_0008;
		io_write(pic_adr(2), edge_m);
		io_write(pic_adr(3), 32'd3);              // drop a stale tick
		io_write(pic_adr(1), enable_m);
		wait_irq(1'b0, 10);
		wait_irq(1'b1, 120);
		@(negedge clk_i);
		check_val("tick cause", 32'(model_cause(32'h8)), 32'(cause_o));
		io_write(pic_adr(3), 32'd3);
		wait_irq(1'b0, 10);
		wait_irq(1'b1, 120);
		@(negedge clk_i);
		check_val("second tick cause", 32'(model_cause(32'h8)), 32'(cause_o));
		test_done("tick", e);

		$display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+test
common/mpu_pkg.sv
common/cpu_bus_if.sv
hw/tick_gen.sv
pic/irq_capture.sv
pic/pic_ctrl.sv
mmu/page_mapper.sv
hw/bus_responder.sv
hw/mpu_top.sv
test/tb_mpu.sv
